/* dma_initiator_resp.sv */
/*
 * Response path of the DMA initiator.
 * NoC response flits pass through a packet buffer into the response handler,
 * which writes read data over Wishbone and reports finished transfers.
 */
`timescale 1ns/100ps

module dma_initiator_resp (
  input  logic                                clk,
  input  logic                                rst,

  // NoC response input
  input  dma_pkg::flit_t                      noc_in_flit_i,
  input  logic                                noc_in_valid_i,
  output logic                                noc_in_ready_o,

  // Wishbone master
  output logic [dma_pkg::content_width-1:0]   wb_adr_o,
  output logic [dma_pkg::content_width-1:0]   wb_dat_o,
  output logic [dma_pkg::word_bytes-1:0]      wb_sel_o,
  output logic                                wb_we_o,
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic [2:0]                          wb_cti_o,
  output logic [1:0]                          wb_bte_o,
  input  logic                                wb_ack_i,

  // Completion towards the transfer table
  output logic [dma_pkg::table_ptr_width-1:0] done_pos_o,
  output logic                                done_en_o
);

  import dma_pkg::*;

  // Whole packets only, from buffer to handler
  flit_t buf_flit;
  logic  buf_valid;
  logic  buf_ready;

  dma_packet_buffer buffer_i (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (noc_in_flit_i),
    .in_valid_i  (noc_in_valid_i),
    .in_ready_o  (noc_in_ready_o),
    .out_flit_o  (buf_flit),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready)
  );

  dma_response_handler handler_i (
    .clk         (clk),
    .rst         (rst),
    .buf_flit_i  (buf_flit),
    .buf_valid_i (buf_valid),
    .buf_ready_o (buf_ready),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .wb_sel_o    (wb_sel_o),
    .wb_we_o     (wb_we_o),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_cti_o    (wb_cti_o),
    .wb_bte_o    (wb_bte_o),
    .wb_ack_i    (wb_ack_i),
    .done_pos_o  (done_pos_o),
    .done_en_o   (done_en_o)
  );

endmodule

/* dma_initiator_resp_properties.sv */
/*
 * Concurrent checks on the Wishbone master and the done strobe of the
 * response path, attached to the top level with bind.
 */
`timescale 1ns/100ps

module dma_initiator_resp_properties (
  input logic                                clk,
  input logic                                rst,
  input logic                                cyc_i,
  input logic                                stb_i,
  input logic                                ack_i,
  input logic [dma_pkg::content_width-1:0]   adr_i,
  input logic [dma_pkg::content_width-1:0]   dat_i,
  input logic [dma_pkg::word_bytes-1:0]      sel_i,
  input logic [dma_pkg::table_ptr_width-1:0] done_pos_i,
  input logic                                done_en_i
);

  // Strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb_i |-> cyc_i)
    else $error("wb_stb_o high without wb_cyc_o");

  // Waiting beat keeps its address and data
  beat_stable: assert property (@(posedge clk) disable iff (rst)
    (stb_i && !ack_i) |=> ($stable(adr_i) && $stable(dat_i)))
    else $error("wb_adr_o or wb_dat_o changed before ack");

  sel_full: assert property (@(posedge clk) disable iff (rst) stb_i |-> (sel_i == '1))
    else $error("wb_sel_o not all ones during a beat");

  // Back to back pulses belong to different slots
  done_single: assert property (@(posedge clk) disable iff (rst)
    done_en_i |=> (!done_en_i || (done_pos_i != $past(done_pos_i))))
    else $error("done_en_o held for one slot longer than a cycle");

endmodule

bind dma_initiator_resp dma_initiator_resp_properties props_i (
  .clk        (clk),
  .rst        (rst),
  .cyc_i      (wb_cyc_o),
  .stb_i      (wb_stb_o),
  .ack_i      (wb_ack_i),
  .adr_i      (wb_adr_o),
  .dat_i      (wb_dat_o),
  .sel_i      (wb_sel_o),
  .done_pos_i (done_pos_o),
  .done_en_i  (done_en_o)
);

/* dma_packet_buffer.sv */
/*
 * Store-and-forward flit FIFO between the NoC input and the response handler.
 * Flits are released only once the whole packet sits in the FIFO, so the
 * handler never stalls the NoC in the middle of a packet.
 */
`timescale 1ns/100ps

module dma_packet_buffer (
  input  logic           clk,
  input  logic           rst,

  // Flits from the NoC
  input  dma_pkg::flit_t in_flit_i,
  input  logic           in_valid_i,
  output logic           in_ready_o,

  // Flits towards the response handler
  output dma_pkg::flit_t out_flit_o,
  output logic           out_valid_o,
  input  logic           out_ready_i
);

  import dma_pkg::*;

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  flit_t                     mem [noc_packet_size];
  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic [fifo_cnt_width-1:0] flit_cnt;

  // Complete packets held, counted by their closing flit
  logic [fifo_cnt_width-1:0] pkt_cnt;

  logic push;
  logic pop;
  logic push_end;
  logic pop_end;

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  // Back-pressure the NoC only when every slot is taken
  assign in_ready_o = (flit_cnt != fifo_cnt_width'(noc_packet_size));

  // Head flit comes straight out of the array
  assign out_flit_o = mem[rd_ptr];

  // Registered count, so the closing flit is always stored a cycle earlier
  assign out_valid_o = (pkt_cnt != '0);

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  assign push_end = push & flit_is_end(in_flit_i);
  assign pop_end  = pop & flit_is_end(out_flit_o);

  ////////////////////////////////////////
  // Array write
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  ////////////////////////////////////////
  // Pointer and counter update
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      flit_cnt <= '0;
      pkt_cnt  <= '0;
    end else begin
      // Depth is a power of two so pointers wrap by themselves
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // Flit fill level
      case ({push, pop})
        2'b10:   flit_cnt <= flit_cnt + 1'b1;
        2'b01:   flit_cnt <= flit_cnt - 1'b1;
        default: flit_cnt <= flit_cnt;
      endcase

      // A packet written and another drained in one cycle cancel out
      case ({push_end, pop_end})
        2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
        2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
        default: pkt_cnt <= pkt_cnt;
      endcase
    end
  end

endmodule

/* dma_pkg.sv */
/*
 * Shared definitions for the DMA initiator response path.
 * Holds flit and packet field positions, type codes, widths, Wishbone
 * burst codes and the handler state encoding. Modules import it in their body.
 */
package dma_pkg;

  ////////////////////////////////////////
  // Flit format
  ////////////////////////////////////////

  // Two flit type bits sit above a 32 bit content word
  localparam int flit_width    = 34;
  localparam int content_width = 32;
  localparam int flit_type_lsb = 32;
  localparam int flit_type_msb = 33;

  typedef logic [flit_width-1:0] flit_t;

  localparam logic [1:0] flit_type_payload = 2'b00;
  localparam logic [1:0] flit_type_first   = 2'b01;
  localparam logic [1:0] flit_type_last    = 2'b10;
  localparam logic [1:0] flit_type_single  = 2'b11;

  ////////////////////////////////////////
  // Header fields of a response packet
  ////////////////////////////////////////

  localparam int packet_type_lsb  = 12;
  localparam int packet_type_msb  = 13;
  localparam int packet_id_lsb    = 0;
  localparam int packet_id_msb    = 1;
  localparam int packet_resp_last = 2;

  localparam logic [1:0] packet_type_l2r_resp = 2'b10;
  localparam logic [1:0] packet_type_r2l_resp = 2'b11;

  // Transfer table slots
  localparam int table_entries   = 4;
  localparam int table_ptr_width = $clog2(table_entries);

  // Largest packet, also the depth of the packet buffer
  localparam int noc_packet_size = 16;
  localparam int fifo_ptr_width  = $clog2(noc_packet_size);
  localparam int fifo_cnt_width  = fifo_ptr_width + 1;

  ////////////////////////////////////////
  // Wishbone burst
  ////////////////////////////////////////

  // Address step per word, also one select bit per byte
  localparam int word_bytes = 4;

  localparam logic [2:0] cti_incr   = 3'b010;
  localparam logic [2:0] cti_end    = 3'b111;
  localparam logic [1:0] bte_linear = 2'b00;

  // Response handler states
  typedef enum logic [1:0] {
    st_idle     = 2'b00,
    st_get_addr = 2'b01,
    st_data     = 2'b10,
    st_get_size = 2'b11
  } handler_state_t;

  // True for the flit that closes a packet
  function automatic logic flit_is_end(flit_t flit);
    return (flit[flit_type_msb:flit_type_lsb] == flit_type_last) ||
           (flit[flit_type_msb:flit_type_lsb] == flit_type_single);
  endfunction

endpackage

/* dma_response_handler.sv */
/*
 * Decodes response packets from the packet buffer.
 * Completions pulse done with their table slot. Read responses are written
 * to local memory as a Wishbone incrementing burst, then done is pulsed
 * when the response's last packet has been written.
 */
`timescale 1ns/100ps

module dma_response_handler (
  input  logic                                clk,
  input  logic                                rst,

  // Head of the packet buffer
  input  dma_pkg::flit_t                      buf_flit_i,
  input  logic                                buf_valid_i,
  output logic                                buf_ready_o,

  // Wishbone master, write bursts only
  output logic [dma_pkg::content_width-1:0]   wb_adr_o,
  output logic [dma_pkg::content_width-1:0]   wb_dat_o,
  output logic [dma_pkg::word_bytes-1:0]      wb_sel_o,
  output logic                                wb_we_o,
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic [2:0]                          wb_cti_o,
  output logic [1:0]                          wb_bte_o,
  input  logic                                wb_ack_i,

  // Transfer completion
  output logic [dma_pkg::table_ptr_width-1:0] done_pos_o,
  output logic                                done_en_o
);

  import dma_pkg::*;

  ////////////////////////////////////////
  // State and latched header fields
  ////////////////////////////////////////

  handler_state_t state;
  handler_state_t nxt_state;

  // Burst address that steps one word per ack
  logic [content_width-1:0] resp_addr;
  logic [content_width-1:0] nxt_resp_addr;

  // Slot id and resp-last flag of the packet in flight
  logic [table_ptr_width-1:0] resp_id;
  logic [table_ptr_width-1:0] nxt_resp_id;
  logic                       resp_last;
  logic                       nxt_resp_last;

  ////////////////////////////////////////
  // Header decode of the buffer head
  ////////////////////////////////////////

  logic [1:0]                 hdr_type;
  logic [table_ptr_width-1:0] hdr_id;
  logic                       hdr_last;
  logic                       beat_last;

  assign hdr_type = buf_flit_i[packet_type_msb:packet_type_lsb];
  assign hdr_id   = buf_flit_i[packet_id_msb:packet_id_lsb];
  assign hdr_last = buf_flit_i[packet_resp_last];

  // Closing flit of the packet is the final beat of the burst
  assign beat_last = flit_is_end(buf_flit_i);

  // Data beat taken straight from the buffer head
  assign wb_adr_o = resp_addr;
  assign wb_dat_o = buf_flit_i[content_width-1:0];

  // Full word writes in linear bursts
  assign wb_sel_o = '1;
  assign wb_bte_o = bte_linear;

  ////////////////////////////////////////
  // Next state and bus outputs
  ////////////////////////////////////////

  always_comb begin
    // Hold everything by default
    nxt_state     = state;
    nxt_resp_addr = resp_addr;
    nxt_resp_id   = resp_id;
    nxt_resp_last = resp_last;

    buf_ready_o = 1'b0;
    wb_cyc_o    = 1'b0;
    wb_stb_o    = 1'b0;
    wb_we_o     = 1'b0;
    wb_cti_o    = 3'b000;
    done_en_o   = 1'b0;
    done_pos_o  = '0;

    case (state)
      st_idle: begin
        // Header is always consumed in one cycle
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          nxt_resp_id   = hdr_id;
          nxt_resp_last = hdr_last;
          if (hdr_type == packet_type_l2r_resp) begin
            // Single flit completion
            done_en_o  = 1'b1;
            done_pos_o = hdr_id;
          end else if (hdr_type == packet_type_r2l_resp) begin
            nxt_state = st_get_size;
          end
          // Unknown packet classes are dropped here
        end
      end

      st_get_size: begin
        // Size flit carries nothing the burst needs
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          nxt_state = st_get_addr;
        end
      end

      st_get_addr: begin
        buf_ready_o = 1'b1;
        if (buf_valid_i) begin
          nxt_resp_addr = buf_flit_i[content_width-1:0];
          nxt_state     = st_data;
        end
      end

      st_data: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
        wb_we_o  = 1'b1;
        wb_cti_o = beat_last ? cti_end : cti_incr;
        // Flit leaves the buffer only with the ack
        if (wb_ack_i) begin
          buf_ready_o   = 1'b1;
          nxt_resp_addr = resp_addr + content_width'(word_bytes);
          if (beat_last) begin
            nxt_state = st_idle;
            if (resp_last) begin
              done_en_o  = 1'b1;
              done_pos_o = resp_id;
            end
          end
        end
      end

      default: begin
        nxt_state = st_idle;
      end
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= nxt_state;
    end
  end

  // Burst address and latched header fields
  always_ff @(posedge clk) begin
    resp_addr <= nxt_resp_addr;
    resp_id   <= nxt_resp_id;
    resp_last <= nxt_resp_last;
  end

endmodule

/* list.f */
dma_pkg.sv
dma_packet_buffer.sv
dma_response_handler.sv
dma_initiator_resp.sv
dma_initiator_resp_properties.sv
tb_dma_initiator_resp.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_dma_initiator_resp -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "sim passed" \
  && echo "run: pass" \
  || { echo "run: fail"; exit 1; }

/* tb_dma_initiator_resp.sv */
/*
 * Directed testbench for the DMA initiator response path.
 * Sends response packets on the NoC input, serves the Wishbone writes from a
 * small memory model and checks memory contents, burst codes and done pulses.
 */
`timescale 1ns/100ps

module tb_dma_initiator_resp;

  import dma_pkg::*;

  // Longest test moves 21 flits and 14 beats, under 150 cycles with
  // 3 stall cycles per beat, so the whole run stays far below this
  localparam int timeout_cycles = 4000;

  logic                       clk;
  logic                       rst;
  flit_t                      noc_flit;
  logic                       noc_valid;
  logic                       noc_ready;
  logic [content_width-1:0]   wb_adr;
  logic [content_width-1:0]   wb_dat;
  logic [word_bytes-1:0]      wb_sel;
  logic                       wb_we;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic [2:0]                 wb_cti;
  logic [1:0]                 wb_bte;
  logic                       wb_ack;
  logic [table_ptr_width-1:0] done_pos;
  logic                       done_en;

  ////////////////////////////////////////
  // Test state and logs
  ////////////////////////////////////////

  logic [31:0] mem [64];
  flit_t       tx_q [$];
  logic [31:0] beat_adr_q [$];
  logic [2:0]  beat_cti_q [$];
  logic [31:0] done_id_q [$];
  int          done_beat_q [$];
  logic        stall_en;
  logic        ready_low_seen;
  int          stb_cycles;
  logic [31:0] rng = 32'd10;
  int          cycle_cnt = 0;
  int          test_err = 0;
  int          err_total = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        run_over = 1'b0;

  dma_initiator_resp dut_i (
    .clk            (clk),
    .rst            (rst),
    .noc_in_flit_i  (noc_flit),
    .noc_in_valid_i (noc_valid),
    .noc_in_ready_o (noc_ready),
    .wb_adr_o       (wb_adr),
    .wb_dat_o       (wb_dat),
    .wb_sel_o       (wb_sel),
    .wb_we_o        (wb_we),
    .wb_cyc_o       (wb_cyc),
    .wb_stb_o       (wb_stb),
    .wb_cti_o       (wb_cti),
    .wb_bte_o       (wb_bte),
    .wb_ack_i       (wb_ack),
    .done_pos_o     (done_pos),
    .done_en_o      (done_en)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      run_over = 1'b1;
      $display("sim failed");
      $finish;
    end
  end

  // Runs cut short elsewhere, e.g. by a failed assertion
  final begin
    if (!run_over) begin
      $display("sim failed");
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Data word tagged per test, tied to its byte address
  function automatic logic [31:0] data_word(input logic [7:0] tag, input logic [31:0] a);
    return {tag, 8'h5a, a[15:0]};
  endfunction

  function automatic logic [31:0] header(input logic [1:0] ptype, input logic [1:0] id,
                                         input logic last);
    logic [31:0] h;
    h = '0;
    h[packet_type_msb:packet_type_lsb] = ptype;
    h[packet_id_msb:packet_id_lsb]     = id;
    h[packet_resp_last]                = last;
    return h;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
    test_err++;
  endtask

  task automatic report_problem(input string msg);
    $display("error: %s", msg);
    test_err++;
  endtask

  task automatic start_test(input logic stall);
    tx_q.delete();
    beat_adr_q.delete();
    beat_cti_q.delete();
    done_id_q.delete();
    done_beat_q.delete();
    stb_cycles     = 0;
    ready_low_seen = 1'b0;
    test_err       = 0;
    stall_en       = stall;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'hbeef_0000 | 32'(i * 4);
    end
  endtask

  task automatic finish_test(input string name);
    if (test_err == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_err);
      tests_failed++;
    end
    tests_run++;
    err_total += test_err;
  endtask

  // Single flit completion
  task automatic add_completion(input logic [1:0] id);
    tx_q.push_back({flit_type_single, header(packet_type_l2r_resp, id, 1'b1)});
  endtask

  // Header, size, address, then n data flits, the final one closing the packet
  task automatic add_write(input logic [7:0] tag, input logic [1:0] id, input logic last,
                           input logic [31:0] base, input int n);
    logic [31:0] a;
    tx_q.push_back({flit_type_first, header(packet_type_r2l_resp, id, last)});
    tx_q.push_back({flit_type_payload, 32'(n)});
    tx_q.push_back({flit_type_payload, base});
    for (int k = 0; k < n; k++) begin
      a = base + 32'(k * 4);
      tx_q.push_back({(k == n - 1) ? flit_type_last : flit_type_payload, data_word(tag, a)});
    end
  endtask

  // Valid/ready sender, ready sampled mid-cycle
  task automatic send_flits();
    while (tx_q.size() > 0) begin
      noc_flit  = tx_q.pop_front();
      noc_valid = 1'b1;
      @(negedge clk);
      while (!noc_ready) @(negedge clk);
      @(posedge clk);
      #2;
    end
    noc_valid = 1'b0;
  endtask

  task automatic wait_done(input int n);
    while (done_id_q.size() < n) @(posedge clk);
    // Quiet time to catch an extra pulse or beat
    repeat (6) @(posedge clk);
    #2;
  endtask

  task automatic check_mem(input string name, input logic [7:0] tag,
                           input logic [31:0] base, input int n);
    logic [31:0] a;
    for (int k = 0; k < n; k++) begin
      a = base + 32'(k * 4);
      if (mem[a[7:2]] !== data_word(tag, a)) begin
        report_mismatch({name, " mem"}, data_word(tag, a), mem[a[7:2]]);
      end
    end
  endtask

  task automatic check_done(input string name, input int idx, input int exp_id,
                            input int exp_beats);
    if (done_id_q[idx] !== 32'(exp_id)) begin
      report_mismatch({name, " done id"}, 32'(exp_id), done_id_q[idx]);
    end
    if (done_beat_q[idx] != exp_beats) begin
      report_mismatch({name, " beats before done"}, exp_beats, done_beat_q[idx]);
    end
  endtask

  ////////////////////////////////////////
  // Wishbone memory model and monitor
  ////////////////////////////////////////

  initial begin : wb_slave
    int   wait_left;
    logic beat;
    wb_ack    = 1'b0;
    wait_left = -1;
    forever begin
      @(negedge clk);
      // Ack held across the coming edge, so this beat completes there
      beat = wb_cyc && wb_stb && wb_ack;
      if (beat) begin
        mem[wb_adr[7:2]] = wb_dat;
        beat_adr_q.push_back(wb_adr);
        beat_cti_q.push_back(wb_cti);
        if (!wb_we || wb_bte != 2'b00) begin
          report_problem("write beat without we or with a non-linear bte");
        end
      end else if (wb_stb && wait_left < 0) begin
        rng       = xorshift(rng);
        wait_left = stall_en ? int'(rng % 32'd4) : 0;
      end
      if (wb_stb) begin
        stb_cycles++;
      end
      if (!noc_ready) begin
        ready_low_seen = 1'b1;
      end
      // Logged after the beat so the count includes a final ack
      if (done_en) begin
        done_id_q.push_back(32'(done_pos));
        done_beat_q.push_back(beat_adr_q.size());
      end
      @(posedge clk);
      #2;
      if (beat) begin
        wb_ack = 1'b0;
      end else if (wait_left == 0) begin
        wb_ack    = 1'b1;
        wait_left = -1;
      end else if (wait_left > 0) begin
        wait_left--;
      end
    end
  end

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_completions();
    start_test(1'b0);
    for (int id = 0; id < table_entries; id++) begin
      add_completion(id[1:0]);
    end
    send_flits();
    wait_done(4);
    if (done_id_q.size() != 4) begin
      report_mismatch("completions done count", 4, done_id_q.size());
    end else begin
      for (int id = 0; id < 4; id++) begin
        check_done("completions", id, id, 0);
      end
    end
    if (stb_cycles != 0) begin
      report_problem("completions: Wishbone strobe raised for a completion");
    end
    finish_test("completions");
  endtask

  // Also reused with slave stalls
  task automatic test_single_write(input string name, input logic stall);
    logic [2:0] exp_cti;
    start_test(stall);
    add_write(8'h21, 2'd2, 1'b1, 32'h40, 5);
    send_flits();
    wait_done(1);
    check_mem(name, 8'h21, 32'h40, 5);
    if (beat_cti_q.size() != 5) begin
      report_mismatch({name, " beat count"}, 5, beat_cti_q.size());
    end else begin
      for (int k = 0; k < 5; k++) begin
        exp_cti = (k == 4) ? 3'b111 : 3'b010;
        if (beat_cti_q[k] !== exp_cti) begin
          report_mismatch({name, " cti"}, 32'(exp_cti), 32'(beat_cti_q[k]));
        end
      end
    end
    if (done_id_q.size() != 1) begin
      report_mismatch({name, " done count"}, 1, done_id_q.size());
    end else begin
      check_done(name, 0, 2, 5);
    end
    finish_test(name);
  endtask

  task automatic test_multi_packet();
    start_test(1'b0);
    add_write(8'h33, 2'd1, 1'b0, 32'h00, 3);
    add_write(8'h33, 2'd1, 1'b1, 32'h80, 4);
    send_flits();
    wait_done(1);
    check_mem("multi_packet", 8'h33, 32'h00, 3);
    check_mem("multi_packet", 8'h33, 32'h80, 4);
    if (done_id_q.size() != 1) begin
      report_mismatch("multi_packet done count", 1, done_id_q.size());
    end else begin
      check_done("multi_packet", 0, 1, 7);
    end
    finish_test("multi_packet");
  endtask

  task automatic test_backpressure();
    logic [31:0] exp_adr;
    start_test(1'b1);
    add_write(8'h55, 2'd1, 1'b1, 32'h60, 11);
    add_completion(2'd2);
    add_write(8'h55, 2'd3, 1'b1, 32'ha0, 3);
    send_flits();
    wait_done(3);
    if (!ready_low_seen) begin
      report_problem("backpressure: noc_in_ready_o never dropped");
    end
    // Beat order follows packet order
    if (beat_adr_q.size() != 14) begin
      report_mismatch("backpressure beat count", 14, beat_adr_q.size());
    end else begin
      for (int k = 0; k < 14; k++) begin
        exp_adr = (k < 11) ? 32'h60 + 32'(k * 4) : 32'ha0 + 32'((k - 11) * 4);
        if (beat_adr_q[k] !== exp_adr) begin
          report_mismatch("backpressure beat address", exp_adr, beat_adr_q[k]);
        end
      end
    end
    check_mem("backpressure", 8'h55, 32'h60, 11);
    check_mem("backpressure", 8'h55, 32'ha0, 3);
    if (done_id_q.size() != 3) begin
      report_mismatch("backpressure done count", 3, done_id_q.size());
    end else begin
      check_done("backpressure", 0, 1, 11);
      check_done("backpressure", 1, 2, 11);
      check_done("backpressure", 2, 3, 14);
    end
    finish_test("backpressure");
  endtask

  initial begin
    rst       = 1'b1;
    noc_flit  = '0;
    noc_valid = 1'b0;
    stall_en  = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    test_completions();
    test_single_write("r2l_write", 1'b0);
    test_multi_packet();
    test_single_write("slave_stalls", 1'b1);
    test_backpressure();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
    run_over = 1'b1;
    if (err_total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
